//--- design/lat_mem_config.svh
/*
  size and latency macros of the latency memory
  data width, word count, write and read delay stages
*/

`ifndef LAT_MEM_CONFIG_SVH
`define LAT_MEM_CONFIG_SVH

// width of one user data word in bits
`define LM_DATA_WIDTH 8

// number of words held in the array
// the address width is derived from it in the bus package
`define LM_MEM_DEPTH 16

// register stages between the controller and the array write port
// one stage is the minimum
`define LM_WR_LATENCY 3

// register stages between the array read port and the decoder
// one stage is the minimum
`define LM_RD_LATENCY 2

`endif

//--- design/lat_mem_ecc_pkg.sv
/*
  hamming code types and helpers
  parity count, code word, syndrome, position and coverage functions
*/

`default_nettype none

`include "lat_mem_config.svh"

package lat_mem_ecc_pkg;

  // one parity bit per address bit of the code position plus one
  localparam int parity_bits = $clog2(`LM_DATA_WIDTH) + 1;
  localparam int code_width  = `LM_DATA_WIDTH + parity_bits;

  // positions run from 1 and parity sits at the powers of two
  typedef logic [code_width:1] code_word_t;

  // zero means a clean word, anything else points at the flipped position
  typedef logic [parity_bits-1:0] syndrome_t;

  // true for the parity positions 1, 2, 4, 8 and so on
  function automatic logic is_parity_pos(int pos);
    return (pos & (pos - 1)) == 0;
  endfunction

  // xor of every code bit whose position has bit p set
  // the encoder calls it with the parity positions still zero
  // and the decoder calls it on the full word to get one syndrome bit
  function automatic logic cover_parity(code_word_t code, int p);
    logic acc;
    acc = 1'b0;
    for (int pos = 1; pos <= code_width; pos++)
    begin
      if (((pos >> p) & 1) != 0)
      begin
        acc ^= code[pos];
      end
    end
    return acc;
  endfunction

endpackage

`default_nettype wire

//--- design/lat_mem_bus_pkg.sv
/*
  bus and control types of the latency memory
  address and data words, delayed command, controller states
*/

`default_nettype none

`include "lat_mem_config.svh"

package lat_mem_bus_pkg;

  // address covers every word of the array
  typedef logic [$clog2(`LM_MEM_DEPTH)-1:0] addr_t;

  // plain user data as seen on the wishbone side
  typedef logic [`LM_DATA_WIDTH-1:0] data_t;

  // command that walks through the write delay line
  // the code word is only meaningful when we is set
  typedef struct packed {
    logic                       we;
    addr_t                      adr;
    lat_mem_ecc_pkg::code_word_t code;
  } mem_cmd_t;

  // one transfer in flight at a time
  // ST_ACK is the single acknowledge cycle before going idle again
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WAIT,
    ST_ACK
  } ctrl_state_t;

endpackage

`default_nettype wire

//--- design/lat_delay_line.sv
/*
  register delay line of DEPTH stages and WIDTH bits
  with a valid bit carried alongside each stage
*/

`timescale 1ns/1ps
`default_nettype none

module lat_delay_line
#(
  parameter int DEPTH = 1,
  parameter int WIDTH = 1
)
(
  input  wire logic             clka,
  input  wire logic             i_arst_n,
  input  wire logic             i_valid,
  input  wire logic [WIDTH-1:0] i_data,
  output logic                  o_valid,
  output logic [WIDTH-1:0]      o_data
);

  // stage 0 is loaded from the input and stage DEPTH-1 drives the output
  logic [DEPTH-1:0] valid_q;
  logic [WIDTH-1:0] data_q [DEPTH];

  // valid chain comes out of reset empty so no stale strobe leaks out
  always_ff @(posedge clka or negedge i_arst_n)
  begin
    if (!i_arst_n)
    begin
      valid_q <= '0;
    end
    else
    begin
      valid_q[0] <= i_valid;
      for (int s = 1; s < DEPTH; s++)
      begin
        valid_q[s] <= valid_q[s-1];
      end
    end
  end

  // data just shifts every cycle, its meaning comes from the valid bit
  always_ff @(posedge clka)
  begin
    data_q[0] <= i_data;
    for (int s = 1; s < DEPTH; s++)
    begin
      data_q[s] <= data_q[s-1];
    end
  end

  assign o_valid = valid_q[DEPTH-1];
  assign o_data  = data_q[DEPTH-1];

endmodule

`default_nettype wire

//--- design/hamming_encoder.sv
/*
  combinational hamming encoder
  places data bits, fills parity bits, optional single bit injection
*/

`timescale 1ns/1ps
`default_nettype none

module hamming_encoder
(
  input  wire lat_mem_bus_pkg::data_t     i_data,
  input  wire logic                       i_inj_en,
  input  wire lat_mem_ecc_pkg::syndrome_t i_inj_pos,
  output lat_mem_ecc_pkg::code_word_t     o_code
);

  import lat_mem_ecc_pkg::*;

  code_word_t code_c;
  int         data_idx;

  always_comb
  begin
    code_c   = '0;
    data_idx = 0;

    // data bits fill the positions that are not a power of two
    // from the lowest position upwards
    for (int pos = 1; pos <= code_width; pos++)
    begin
      if (!is_parity_pos(pos))
      begin
        code_c[pos] = i_data[data_idx];
        data_idx++;
      end
    end

    // parity positions are still zero here so each parity bit
    // only sums the data bits it covers
    for (int p = 0; p < parity_bits; p++)
    begin
      code_c[1 << p] = cover_parity(code_c, p);
    end

    // flip the selected position to exercise the decoder
    // position zero or one past the word leaves the code untouched
    if (i_inj_en && (i_inj_pos != '0) && (int'(i_inj_pos) <= code_width))
    begin
      code_c[i_inj_pos] = ~code_c[i_inj_pos];
    end
  end

  assign o_code = code_c;

endmodule

`default_nettype wire

//--- design/hamming_decoder.sv
/*
  combinational hamming decoder
  syndrome, single bit correction, data extraction, error flag
*/

`timescale 1ns/1ps
`default_nettype none

module hamming_decoder
(
  input  wire lat_mem_ecc_pkg::code_word_t i_code,
  output lat_mem_bus_pkg::data_t           o_data,
  output logic                             o_err
);

  import lat_mem_bus_pkg::*;
  import lat_mem_ecc_pkg::*;

  syndrome_t  syndrome;
  code_word_t fixed_c;
  data_t      data_c;
  int         data_idx;

  // each syndrome bit rechecks one parity group including its parity bit
  // so a clean word gives zero
  always_comb
  begin
    for (int p = 0; p < parity_bits; p++)
    begin
      syndrome[p] = cover_parity(i_code, p);
    end
  end

  always_comb
  begin
    fixed_c = i_code;

    // a single flipped bit makes the syndrome equal to its position
    // values past the end of the word cannot come from one flip
    if ((syndrome != '0) && (int'(syndrome) <= code_width))
    begin
      fixed_c[syndrome] = ~fixed_c[syndrome];
    end
  end

  // gather the data bits back in the order the encoder placed them
  always_comb
  begin
    data_c   = '0;
    data_idx = 0;
    for (int pos = 1; pos <= code_width; pos++)
    begin
      if (!is_parity_pos(pos))
      begin
        data_c[data_idx] = fixed_c[pos];
        data_idx++;
      end
    end
  end

  assign o_data = data_c;

  // flag any non zero syndrome, also when the flip hit a parity bit
  assign o_err = (syndrome != '0);

endmodule

`default_nettype wire

//--- design/ecc_ram.sv
/*
  storage array of encoded words
  synchronous write, registered read on one shared address
*/

`timescale 1ns/1ps
`default_nettype none

`include "lat_mem_config.svh"

module ecc_ram
(
  input  wire logic                        clka,
  input  wire logic                        i_we,
  input  wire lat_mem_bus_pkg::addr_t      i_adr,
  input  wire lat_mem_ecc_pkg::code_word_t i_code,
  output lat_mem_ecc_pkg::code_word_t      o_code
);

  import lat_mem_ecc_pkg::*;

  localparam int mem_depth = `LM_MEM_DEPTH;

  // contents are undefined until the first write to each address
  code_word_t mem [mem_depth];

  always_ff @(posedge clka)
  begin
    if (i_we)
    begin
      mem[i_adr] <= i_code;
    end
    // read happens every cycle and returns the old word on a write
    o_code <= mem[i_adr];
  end

endmodule

`default_nettype wire

//--- design/lat_mem_ctrl.sv
/*
  wishbone classic slave controller
  accepts one request, launches it and waits for the matching done strobe
*/

`timescale 1ns/1ps
`default_nettype none

module lat_mem_ctrl
(
  input  wire logic                   clka,
  input  wire logic                   i_arst_n,
  input  wire logic                   i_cyc,
  input  wire logic                   i_stb,
  input  wire logic                   i_we,
  input  wire lat_mem_bus_pkg::addr_t i_adr,
  input  wire logic                   i_wr_done,
  input  wire logic                   i_rd_done,
  output logic                        o_launch,
  output logic                        o_cmd_we,
  output lat_mem_bus_pkg::addr_t      o_cmd_adr,
  output logic                        o_ack
);

  import lat_mem_bus_pkg::*;

  ctrl_state_t state_q;
  logic        req;
  logic        done;

  // a valid wishbone request needs both cycle and strobe
  assign req = i_cyc & i_stb;

  // pick the strobe of the path the transfer actually went through
  // the other line may still carry a stale strobe from an earlier transfer
  assign done = o_cmd_we ? i_wr_done : i_rd_done;

  always_ff @(posedge clka or negedge i_arst_n)
  begin
    if (!i_arst_n)
    begin
      state_q  <= ST_IDLE;
      o_launch <= 1'b0;
      o_cmd_we <= 1'b0;
    end
    else
    begin
      // launch is a one cycle pulse into the write delay line
      o_launch <= 1'b0;
      case (state_q)
        ST_IDLE:
        begin
          if (req)
          begin
            state_q  <= ST_WAIT;
            o_launch <= 1'b1;
            o_cmd_we <= i_we;
          end
        end
        ST_WAIT:
        begin
          if (done)
          begin
            state_q <= ST_ACK;
          end
        end
        ST_ACK:
        begin
          // the master drops or changes its request after seeing ack
          state_q <= ST_IDLE;
        end
        default:
        begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  // the address only matters while the launch pulse is high
  always_ff @(posedge clka)
  begin
    if ((state_q == ST_IDLE) && req)
    begin
      o_cmd_adr <= i_adr;
    end
  end

  assign o_ack = (state_q == ST_ACK);

endmodule

`default_nettype wire

//--- design/lat_mem_top.sv
/*
  latency memory top level
  controller, encoder, write and read delay lines, array and decoder
*/

`timescale 1ns/1ps
`default_nettype none

`include "lat_mem_config.svh"

module lat_mem_top
(
  input  wire logic                       clka,
  input  wire logic                       i_arst_n,
  input  wire logic                       i_cyc,
  input  wire logic                       i_stb,
  input  wire logic                       i_we,
  input  wire lat_mem_bus_pkg::addr_t     i_adr,
  input  wire lat_mem_bus_pkg::data_t     i_dat,
  input  wire logic                       i_inj_err,
  input  wire lat_mem_ecc_pkg::syndrome_t i_inj_pos,
  output logic                            o_ack,
  output lat_mem_bus_pkg::data_t          o_dat,
  output logic                            o_ecc_err
);

  import lat_mem_bus_pkg::*;
  import lat_mem_ecc_pkg::*;

  logic       launch;
  logic       cmd_we;
  addr_t      cmd_adr;
  code_word_t enc_code;
  mem_cmd_t   cmd_in;
  mem_cmd_t   cmd_out;
  logic       wr_valid;
  logic       ram_we;
  logic       rd_start;
  code_word_t ram_code;
  logic       rd_valid;
  code_word_t rd_code;

  lat_mem_ctrl u_ctrl (
    .clka      (clka),
    .i_arst_n  (i_arst_n),
    .i_cyc     (i_cyc),
    .i_stb     (i_stb),
    .i_we      (i_we),
    .i_adr     (i_adr),
    .i_wr_done (wr_valid),
    .i_rd_done (rd_valid),
    .o_launch  (launch),
    .o_cmd_we  (cmd_we),
    .o_cmd_adr (cmd_adr),
    .o_ack     (o_ack)
  );

  // the master holds i_dat until ack so it is still valid with the launch pulse
  hamming_encoder u_enc (
    .i_data    (i_dat),
    .i_inj_en  (i_inj_err),
    .i_inj_pos (i_inj_pos),
    .o_code    (enc_code)
  );

  assign cmd_in = '{we: cmd_we, adr: cmd_adr, code: enc_code};

  lat_delay_line #(
    .DEPTH (`LM_WR_LATENCY),
    .WIDTH ($bits(mem_cmd_t))
  ) u_wr_line (
    .clka     (clka),
    .i_arst_n (i_arst_n),
    .i_valid  (launch),
    .i_data   (cmd_in),
    .o_valid  (wr_valid),
    .o_data   (cmd_out)
  );

  // a command leaving the write line writes on the next edge
  // reads use the same edge to register the addressed word
  assign ram_we   = wr_valid & cmd_out.we;
  assign rd_start = wr_valid & ~cmd_out.we;

  ecc_ram u_ram (
    .clka   (clka),
    .i_we   (ram_we),
    .i_adr  (cmd_out.adr),
    .i_code (cmd_out.code),
    .o_code (ram_code)
  );

  // the read strobe enters one edge before the array word it belongs to
  // so rd_valid leads rd_code by a cycle and the registered ack lines up with the data
  lat_delay_line #(
    .DEPTH (`LM_RD_LATENCY),
    .WIDTH (code_width)
  ) u_rd_line (
    .clka     (clka),
    .i_arst_n (i_arst_n),
    .i_valid  (rd_start),
    .i_data   (ram_code),
    .o_valid  (rd_valid),
    .o_data   (rd_code)
  );

  // outputs are meaningful only while o_ack is high on a read
  hamming_decoder u_dec (
    .i_code (rd_code),
    .o_data (o_dat),
    .o_err  (o_ecc_err)
  );

endmodule

`default_nettype wire

//--- bench/tb_lat_mem.sv
/*
  testbench for the latency memory with hamming protection
  clock, reset, xorshift stimulus, reference model, checks and timeout
*/

`timescale 1ns/1ps
`default_nettype none

`include "lat_mem_config.svh"

module tb_lat_mem;

  import lat_mem_bus_pkg::*;
  import lat_mem_ecc_pkg::*;

  localparam int reset_cycles = 10;
  localparam int random_ops   = 300;
  localparam int depth        = `LM_MEM_DEPTH;
  // directed transfers are the first write and read, the fill, the sweep and the clean rewrite
  localparam int total_ops    = 2 + depth + random_ops + 2 * code_width + 2;
  // a read takes 8 cycles from drive to the next drive, a write fewer
  localparam int cycle_limit  = total_ops * 8 + reset_cycles + 20;
  localparam int wr_lat       = `LM_WR_LATENCY + 1;
  localparam int rd_lat       = `LM_WR_LATENCY + 1 + `LM_RD_LATENCY;

  logic      clka;
  logic      i_arst_n;
  logic      i_cyc;
  logic      i_stb;
  logic      i_we;
  addr_t     i_adr;
  data_t     i_dat;
  logic      i_inj_err;
  syndrome_t i_inj_pos;
  logic      o_ack;
  data_t     o_dat;
  logic      o_ecc_err;

  // reference model with one corrupted flag per address
  data_t       model_mem [depth];
  logic        model_bad [depth];
  logic [31:0] rng_state;
  int          error_count;
  int          check_count;
  int          cycle_count;

  lat_mem_top UUT (
    .clka      (clka),
    .i_arst_n  (i_arst_n),
    .i_cyc     (i_cyc),
    .i_stb     (i_stb),
    .i_we      (i_we),
    .i_adr     (i_adr),
    .i_dat     (i_dat),
    .i_inj_err (i_inj_err),
    .i_inj_pos (i_inj_pos),
    .o_ack     (o_ack),
    .o_dat     (o_dat),
    .o_ecc_err (o_ecc_err)
  );

  always #50 clka = ~clka;

  always @(posedge clka)
  begin
    cycle_count <= cycle_count + 1;
  end

  // a hung handshake never reaches the closing line so the counter ends the run
  initial
  begin
    wait (cycle_count >= cycle_limit);
    $display("timeout: the run did not finish within %0d cycles", cycle_limit);
    $display("SIMULATION FAILED");
    $finish;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic draw_random(output logic [31:0] value);
    rng_state = xorshift32(rng_state);
    value     = rng_state;
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    check_count++;
    if (actual !== expected)
    begin
      error_count++;
      $display("error %s actual 0x%0h expected 0x%0h at %0t", name, actual, expected, $time);
    end
  endtask

  // one wishbone classic transfer, entered and left on a falling edge
  task automatic run_transfer(input logic we, input addr_t adr, input data_t dat,
                              input logic inj, input syndrome_t pos,
                              output data_t rd_dat, output logic rd_err);
    int edges;
    edges     = 0;
    i_cyc     = 1'b1;
    i_stb     = 1'b1;
    i_we      = we;
    i_adr     = adr;
    i_dat     = dat;
    i_inj_err = inj;
    i_inj_pos = pos;
    // the first rising edge after the drive is the acceptance edge
    do
    begin
      @(negedge clka);
      edges++;
    end
    while (!o_ack);
    rd_dat = o_dat;
    rd_err = o_ecc_err;
    check_value("ack_latency", edges - 1, we ? wr_lat : rd_lat);
    i_cyc     = 1'b0;
    i_stb     = 1'b0;
    i_we      = 1'b0;
    i_inj_err = 1'b0;
    // the acknowledge must be gone one cycle later
    @(negedge clka);
    check_value("o_ack", o_ack, 1'b0);
  endtask

  task automatic write_word(input addr_t adr, input data_t dat, input logic inj,
                            input syndrome_t pos);
    data_t unused_dat;
    logic  unused_err;
    run_transfer(1'b1, adr, dat, inj, pos, unused_dat, unused_err);
    model_mem[adr] = dat;
    model_bad[adr] = inj;
  endtask

  // a single flip anywhere in the word is corrected and still reported
  task automatic read_and_check(input addr_t adr);
    data_t got_dat;
    logic  got_err;
    run_transfer(1'b0, adr, '0, 1'b0, '0, got_dat, got_err);
    check_value("o_dat", got_dat, model_mem[adr]);
    check_value("o_ecc_err", got_err, model_bad[adr]);
  endtask

  // code positions run from 1 to code_width
  function automatic syndrome_t pick_position(input logic [31:0] r);
    return syndrome_t'((r % code_width) + 1);
  endfunction

  initial
  begin
    logic [31:0] r;
    addr_t       adr;
    data_t       dat;
    logic        inj;
    clka        = 1'b0;
    i_arst_n    = 1'b0;
    i_cyc       = 1'b0;
    i_stb       = 1'b0;
    i_we        = 1'b0;
    i_adr       = '0;
    i_dat       = '0;
    i_inj_err   = 1'b0;
    i_inj_pos   = '0;
    rng_state   = 32'd84;
    error_count = 0;
    check_count = 0;
    cycle_count = 0;

    repeat (reset_cycles) @(negedge clka);
    i_arst_n = 1'b1;

    // an idle bus must never see an acknowledge
    repeat (6)
    begin
      @(negedge clka);
      check_value("o_ack", o_ack, 1'b0);
    end

    // plain write and read back of one random word
    draw_random(r);
    adr = addr_t'(r[3:0]);
    dat = data_t'(r[15:8]);
    write_word(adr, dat, 1'b0, '0);
    read_and_check(adr);

    // every address holds a known word before random reads start
    for (int a = 0; a < depth; a++)
    begin
      draw_random(r);
      write_word(addr_t'(a), data_t'(r[15:8]), 1'b0, '0);
    end

    // random mix with an occasional injected flip on writes
    for (int n = 0; n < random_ops; n++)
    begin
      draw_random(r);
      adr = addr_t'(r[7:4]);
      dat = data_t'(r[15:8]);
      inj = (r[18:16] == 3'd0);
      if (r[0])
      begin
        write_word(adr, dat, inj, pick_position(r >> 20));
      end
      else
      begin
        read_and_check(adr);
      end
    end

    // sweep every code position, data and parity alike, on one address
    draw_random(r);
    adr = addr_t'(r[3:0]);
    for (int p = 1; p <= code_width; p++)
    begin
      draw_random(r);
      write_word(adr, data_t'(r[7:0]), 1'b1, syndrome_t'(p));
      read_and_check(adr);
    end

    // a clean rewrite clears the corrupted state
    draw_random(r);
    write_word(adr, data_t'(r[7:0]), 1'b0, '0);
    read_and_check(adr);

    $display("checks: %0d errors: %0d", check_count, error_count);
    if (error_count == 0)
    begin
      $display("SIMULATION PASSED");
    end
    else
    begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
+incdir+design
design/lat_mem_ecc_pkg.sv
design/lat_mem_bus_pkg.sv
design/lat_delay_line.sv
design/hamming_encoder.sv
design/hamming_decoder.sv
design/ecc_ram.sv
design/lat_mem_ctrl.sv
design/lat_mem_top.sv
bench/tb_lat_mem.sv
